/* hw/videogen_cfg.svh */
`ifndef VIDEOGEN_CFG_SVH
`define VIDEOGEN_CFG_SVH

// Raster geometry in pixel clocks and lines
`define VG_TOTAL_COLS   384
`define VG_TOTAL_ROWS   288
`define VG_ACTIVE_COLS  288
`define VG_ACTIVE_ROWS  224
`define VG_HSYNC_LEN    32
`define VG_VSYNC_LEN    8
// Porch before the visible window
`define VG_H_BACK       32
`define VG_V_BACK       8

// Datapath widths
`define VG_COORD_W      10
`define VG_DOT_W        8
`define VG_COMP_W       4
`define VG_PAL_W        12
`define VG_IDX_W        9
`define VG_PAL_DEPTH    512

// APB port and address map
`define VG_APB_AW       12
`define VG_APB_DW       32
`define VG_CTRL_ADDR    12'h800

// Gradient generator
`define VG_ACC_W        16
`define VG_COL_STEP     228
`define VG_ROW_STEP     590
`define VG_SPLIT_ROW    112

`endif

/* hw/videogen_pkg.sv */
`default_nettype none

`include "videogen_cfg.svh"

package videogen_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Pixel path types
	////////////////////////////////////////////////////////////////////////////

	// Colour index out of the dot source
	typedef logic [`VG_DOT_W-1:0] dot_t;

	// Single red, green or blue nibble
	typedef logic [`VG_COMP_W-1:0] comp_t;

	// Palette entry, R in [11:8], G in [7:4], B in [3:0]
	typedef logic [`VG_PAL_W-1:0] pal_word_t;

	// Palette address, bank bit on top of the dot
	typedef logic [`VG_IDX_W-1:0] pal_idx_t;

	// Column or row count
	typedef logic [`VG_COORD_W-1:0] coord_t;

	////////////////////////////////////////////////////////////////////////////
	// Palette arbiter
	////////////////////////////////////////////////////////////////////////////

	// Host sequencing around pixel reads
	typedef enum logic [1:0] {
		ARB_IDLE      = 2'd0,
		ARB_HOST_RD   = 2'd1,
		ARB_HOST_DONE = 2'd2
	} arb_state_t;

endpackage

`default_nettype wire

/* hw/video_timing.sv */
`timescale 1ns/1ps
`default_nettype none

`include "videogen_cfg.svh"

module video_timing (
	input  wire logic                 i_clk_6m,
	input  wire logic                 i_rst_n,
	input  wire logic                 i_ctrl_bank,
	output logic                      o_hsync_n,
	output logic                      o_vsync_n,
	output logic                      o_active,
	output videogen_pkg::coord_t      o_col,
	output videogen_pkg::coord_t      o_row,
	output logic                      o_frame_bank
);

	// Window edges in raster coordinates
	// Sync first, then back porch, then active, front porch fills the rest
	localparam videogen_pkg::coord_t H_START = `VG_HSYNC_LEN + `VG_H_BACK;
	localparam videogen_pkg::coord_t H_END   = H_START + `VG_ACTIVE_COLS;
	localparam videogen_pkg::coord_t V_START = `VG_VSYNC_LEN + `VG_V_BACK;
	localparam videogen_pkg::coord_t V_END   = V_START + `VG_ACTIVE_ROWS;
	localparam videogen_pkg::coord_t H_LAST  = `VG_TOTAL_COLS - 1;
	localparam videogen_pkg::coord_t V_LAST  = `VG_TOTAL_ROWS - 1;

	// Raster position over the full frame
	videogen_pkg::coord_t cnt_col;
	videogen_pkg::coord_t cnt_row;

	logic last_col;
	logic last_row;
	logic h_act;
	logic v_act;
	logic frame_start;

	assign last_col    = (cnt_col == H_LAST);
	assign last_row    = (cnt_row == V_LAST);
	assign h_act       = (cnt_col >= H_START) && (cnt_col < H_END);
	assign v_act       = (cnt_row >= V_START) && (cnt_row < V_END);
	// Top left corner of the total raster
	assign frame_start = (cnt_col == '0) && (cnt_row == '0);

	////////////////////////////////////////////////////////////////////////////
	// Free-running counters
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk_6m or negedge i_rst_n) begin
		if (!i_rst_n) begin
			cnt_col <= '0;
			cnt_row <= '0;
		end else if (last_col) begin
			cnt_col <= '0;
			// Row wraps after the last line of the frame
			if (last_row) begin
				cnt_row <= '0;
			end else begin
				cnt_row <= cnt_row + 1'b1;
			end
		end else begin
			cnt_col <= cnt_col + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Registered decode
	////////////////////////////////////////////////////////////////////////////

	// All outputs share one register stage, so they stay aligned
	always_ff @(posedge i_clk_6m or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_hsync_n    <= 1'b1;
			o_vsync_n    <= 1'b1;
			o_active     <= 1'b0;
			o_col        <= '0;
			o_row        <= '0;
			o_frame_bank <= 1'b0;
		end else begin
			// Sync pulses sit at the start of each line and frame
			o_hsync_n <= !(cnt_col < `VG_HSYNC_LEN);
			o_vsync_n <= !(cnt_row < `VG_VSYNC_LEN);
			o_active  <= h_act && v_act;
			// Active coordinates, zero while blanked
			if (h_act && v_act) begin
				o_col <= cnt_col - H_START;
				o_row <= cnt_row - V_START;
			end else begin
				o_col <= '0;
				o_row <= '0;
			end
			// Bank is frozen for the whole frame
			if (frame_start) begin
				o_frame_bank <= i_ctrl_bank;
			end
		end
	end

endmodule

`default_nettype wire

/* hw/dot_pattern.sv */
`timescale 1ns/1ps
`default_nettype none

`include "videogen_cfg.svh"

module dot_pattern (
	input  wire logic                 i_clk_6m,
	input  wire logic                 i_rst_n,
	input  wire logic                 i_active,
	input  wire logic                 i_pat_en,
	input  wire videogen_pkg::coord_t i_col,
	input  wire videogen_pkg::coord_t i_row,
	output videogen_pkg::dot_t        o_dot
);

	// Gradient step sizes at accumulator width
	localparam logic [`VG_ACC_W-1:0] COL_STEP = `VG_COL_STEP;
	localparam logic [`VG_ACC_W-1:0] ROW_STEP = `VG_ROW_STEP;
	localparam videogen_pkg::coord_t SPLIT_ROW = `VG_SPLIT_ROW;

	// Horizontal and vertical phase accumulators
	logic [`VG_ACC_W-1:0] col_acc;
	logic [`VG_ACC_W-1:0] row_acc;
	logic [`VG_ACC_W-1:0] col_nxt;
	logic [`VG_ACC_W-1:0] row_nxt;

	logic first_col;
	logic row_clr;

	assign first_col = (i_col == '0);
	// Pattern restarts at the top and again half way down
	assign row_clr   = (i_row == '0) || (i_row == SPLIT_ROW);

	// Values for the current pixel
	always_comb begin
		col_nxt = col_acc;
		row_nxt = row_acc;
		if (i_active) begin
			if (first_col) begin
				col_nxt = '0;
				if (row_clr) begin
					row_nxt = '0;
				end else begin
					row_nxt = row_acc + ROW_STEP;
				end
			end else begin
				col_nxt = col_acc + COL_STEP;
			end
		end
	end

	always_ff @(posedge i_clk_6m or negedge i_rst_n) begin
		if (!i_rst_n) begin
			col_acc <= '0;
			row_acc <= '0;
			o_dot   <= '0;
		end else begin
			col_acc <= col_nxt;
			row_acc <= row_nxt;
			// Row MSBs on top, column MSBs below
			if (i_active && i_pat_en) begin
				o_dot <= {row_nxt[`VG_ACC_W-1 -: 3], col_nxt[`VG_ACC_W-1 -: 5]};
			end else begin
				o_dot <= '0;
			end
		end
	end

endmodule

`default_nettype wire

/* hw/clut_ram_arb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "videogen_cfg.svh"

module clut_ram_arb (
	input  wire logic                      i_clk_6m,
	input  wire logic                      i_rst_n,
	input  wire logic                      i_pix_req,
	input  wire videogen_pkg::pal_idx_t    i_pix_addr,
	output videogen_pkg::pal_word_t        o_pix_data,
	input  wire logic                      i_host_req,
	input  wire logic                      i_host_we,
	input  wire videogen_pkg::pal_idx_t    i_host_addr,
	input  wire videogen_pkg::pal_word_t   i_host_wdata,
	output logic                           o_host_ack,
	output videogen_pkg::pal_word_t        o_host_rdata
);

	// Palette storage, one port
	videogen_pkg::pal_word_t mem [`VG_PAL_DEPTH];
	videogen_pkg::pal_word_t rd_q;
	// Host read data parked while pixels own the port
	videogen_pkg::pal_word_t hold_q;

	videogen_pkg::arb_state_t state;
	videogen_pkg::arb_state_t state_nxt;
	videogen_pkg::pal_idx_t   mem_addr;

	logic host_slot;
	logic host_wr;
	logic host_rd_start;
	logic mem_rd;

	// Host only gets cycles the pixel path leaves free
	assign host_slot     = i_host_req && !i_pix_req;
	assign host_wr       = host_slot && i_host_we && (state == videogen_pkg::ARB_IDLE);
	assign host_rd_start = host_slot && !i_host_we && (state == videogen_pkg::ARB_IDLE);
	assign mem_rd        = i_pix_req || host_rd_start;
	assign mem_addr      = i_pix_req ? i_pix_addr : i_host_addr;

	always_comb begin
		state_nxt  = state;
		o_host_ack = 1'b0;
		case (state)
			videogen_pkg::ARB_IDLE: begin
				// Writes ack in the free cycle itself
				if (host_wr) begin
					o_host_ack = 1'b1;
				end else if (host_rd_start) begin
					state_nxt = videogen_pkg::ARB_HOST_RD;
				end
			end
			videogen_pkg::ARB_HOST_RD: begin
				// Data ready, hand over unless a pixel steals the cycle
				if (!i_pix_req) begin
					o_host_ack = 1'b1;
					state_nxt  = videogen_pkg::ARB_IDLE;
				end else begin
					state_nxt = videogen_pkg::ARB_HOST_DONE;
				end
			end
			videogen_pkg::ARB_HOST_DONE: begin
				if (host_slot) begin
					o_host_ack = 1'b1;
					state_nxt  = videogen_pkg::ARB_IDLE;
				end
			end
			default: state_nxt = videogen_pkg::ARB_IDLE;
		endcase
	end

	always_ff @(posedge i_clk_6m or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state <= videogen_pkg::ARB_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// Registered read, write and read never share a cycle
	always_ff @(posedge i_clk_6m) begin
		if (host_wr) begin
			mem[i_host_addr] <= i_host_wdata;
		end
		if (mem_rd) begin
			rd_q <= mem[mem_addr];
		end
		if (state == videogen_pkg::ARB_HOST_RD) begin
			hold_q <= rd_q;
		end
	end

	assign o_pix_data   = rd_q;
	assign o_host_rdata = (state == videogen_pkg::ARB_HOST_DONE) ? hold_q : rd_q;

endmodule

`default_nettype wire

/* hw/clut_lookup.sv */
`timescale 1ns/1ps
`default_nettype none

`include "videogen_cfg.svh"

module clut_lookup (
	input  wire logic                      i_clk_6m,
	input  wire logic                      i_rst_n,
	input  wire logic                      i_active,
	input  wire logic                      i_hsync_n,
	input  wire logic                      i_vsync_n,
	input  wire logic                      i_bank,
	input  wire videogen_pkg::dot_t        i_dot,
	output logic                           o_pix_req,
	output videogen_pkg::pal_idx_t         o_pix_addr,
	input  wire videogen_pkg::pal_word_t   i_pix_data,
	output videogen_pkg::comp_t            o_red,
	output videogen_pkg::comp_t            o_green,
	output videogen_pkg::comp_t            o_blue,
	output logic                           o_active,
	output logic                           o_hsync_n,
	output logic                           o_vsync_n
);

	// Stage 1, aligned with the registered dot
	logic act_d1;
	logic hs_d1;
	logic vs_d1;
	logic bank_d1;
	// Stage 2, aligned with palette data
	logic act_d2;
	logic hs_d2;
	logic vs_d2;

	// Palette word split into nibbles
	videogen_pkg::comp_t pix_r;
	videogen_pkg::comp_t pix_g;
	videogen_pkg::comp_t pix_b;

	// Lookup issued straight from the dot register
	assign o_pix_req  = act_d1;
	assign o_pix_addr = {bank_d1, i_dot};

	assign {pix_r, pix_g, pix_b} = i_pix_data;

	////////////////////////////////////////////////////////////////////////////
	// Sync and blank delay line
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk_6m or negedge i_rst_n) begin
		if (!i_rst_n) begin
			act_d1  <= 1'b0;
			hs_d1   <= 1'b1;
			vs_d1   <= 1'b1;
			bank_d1 <= 1'b0;
			act_d2  <= 1'b0;
			hs_d2   <= 1'b1;
			vs_d2   <= 1'b1;
		end else begin
			act_d1  <= i_active;
			hs_d1   <= i_hsync_n;
			vs_d1   <= i_vsync_n;
			bank_d1 <= i_bank;
			act_d2  <= act_d1;
			hs_d2   <= hs_d1;
			vs_d2   <= vs_d1;
		end
	end

	// Output stage, three clocks after the coordinates
	always_ff @(posedge i_clk_6m or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_red     <= '0;
			o_green   <= '0;
			o_blue    <= '0;
			o_active  <= 1'b0;
			o_hsync_n <= 1'b1;
			o_vsync_n <= 1'b1;
		end else begin
			o_active  <= act_d2;
			o_hsync_n <= hs_d2;
			o_vsync_n <= vs_d2;
			// Blanked pixels go black whatever the RAM returned
			o_red     <= act_d2 ? pix_r : '0;
			o_green   <= act_d2 ? pix_g : '0;
			o_blue    <= act_d2 ? pix_b : '0;
		end
	end

endmodule

`default_nettype wire

/* hw/apb_clut_port.sv */
`timescale 1ns/1ps
`default_nettype none

`include "videogen_cfg.svh"

module apb_clut_port (
	input  wire logic                      i_clk_6m,
	input  wire logic                      i_rst_n,
	input  wire logic                      i_psel,
	input  wire logic                      i_penable,
	input  wire logic                      i_pwrite,
	input  wire logic [`VG_APB_AW-1:0]     i_paddr,
	input  wire logic [`VG_APB_DW-1:0]     i_pwdata,
	output logic [`VG_APB_DW-1:0]          o_prdata,
	output logic                           o_pready,
	output logic                           o_host_req,
	output logic                           o_host_we,
	output videogen_pkg::pal_idx_t         o_host_addr,
	output videogen_pkg::pal_word_t        o_host_wdata,
	input  wire logic                      i_host_ack,
	input  wire videogen_pkg::pal_word_t   i_host_rdata,
	output logic                           o_ctrl_bank,
	output logic                           o_ctrl_pat_en
);

	logic access;
	logic is_pal;
	logic is_ctrl;
	logic ctrl_wr;

	// Access phase of the APB transfer
	assign access  = i_psel && i_penable;
	// Palette window below the control register
	assign is_pal  = (i_paddr < `VG_CTRL_ADDR);
	assign is_ctrl = (i_paddr == `VG_CTRL_ADDR);
	assign ctrl_wr = access && i_pwrite && is_ctrl;

	// Palette request held for the whole access phase
	assign o_host_req   = access && is_pal;
	assign o_host_we    = i_pwrite;
	// Word addressed entries
	assign o_host_addr  = i_paddr[`VG_IDX_W+1:2];
	assign o_host_wdata = i_pwdata[`VG_PAL_W-1:0];

	// Register accesses finish at once, palette waits for the arbiter
	assign o_pready = access && (is_pal ? i_host_ack : 1'b1);

	always_comb begin
		o_prdata = '0;
		if (is_pal) begin
			o_prdata[`VG_PAL_W-1:0] = i_host_rdata;
		end else if (is_ctrl) begin
			o_prdata[1:0] = {o_ctrl_pat_en, o_ctrl_bank};
		end
	end

	// Control register
	always_ff @(posedge i_clk_6m or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_ctrl_bank   <= 1'b0;
			o_ctrl_pat_en <= 1'b0;
		end else if (ctrl_wr) begin
			o_ctrl_bank   <= i_pwdata[0];
			o_ctrl_pat_en <= i_pwdata[1];
		end
	end

endmodule

`default_nettype wire

/* hw/videogen_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "videogen_cfg.svh"

module videogen_top (
	input  wire logic                  i_clk_6m,
	input  wire logic                  i_rst_n,
	input  wire logic                  i_psel,
	input  wire logic                  i_penable,
	input  wire logic                  i_pwrite,
	input  wire logic [`VG_APB_AW-1:0] i_paddr,
	input  wire logic [`VG_APB_DW-1:0] i_pwdata,
	output logic [`VG_APB_DW-1:0]      o_prdata,
	output logic                       o_pready,
	output logic                       o_hsync_n,
	output logic                       o_vsync_n,
	output logic                       o_active,
	output logic [`VG_COMP_W-1:0]      o_red,
	output logic [`VG_COMP_W-1:0]      o_green,
	output logic [`VG_COMP_W-1:0]      o_blue
);

	// Timing to dot source and lookup
	logic                   tim_hsync_n;
	logic                   tim_vsync_n;
	logic                   tim_active;
	logic [`VG_COORD_W-1:0] tim_col;
	logic [`VG_COORD_W-1:0] tim_row;
	logic                   frame_bank;
	logic [`VG_DOT_W-1:0]   dot;

	// Palette ports
	logic                   pix_req;
	logic [`VG_IDX_W-1:0]   pix_addr;
	logic [`VG_PAL_W-1:0]   pix_data;
	logic                   host_req;
	logic                   host_we;
	logic [`VG_IDX_W-1:0]   host_addr;
	logic [`VG_PAL_W-1:0]   host_wdata;
	logic                   host_ack;
	logic [`VG_PAL_W-1:0]   host_rdata;

	// Control register
	logic                   ctrl_bank;
	logic                   ctrl_pat_en;

	video_timing u_timing (
		.i_clk_6m(i_clk_6m), .i_rst_n(i_rst_n), .i_ctrl_bank(ctrl_bank),
		.o_hsync_n(tim_hsync_n), .o_vsync_n(tim_vsync_n), .o_active(tim_active),
		.o_col(tim_col), .o_row(tim_row), .o_frame_bank(frame_bank)
	);

	dot_pattern u_dot (
		.i_clk_6m(i_clk_6m), .i_rst_n(i_rst_n), .i_active(tim_active),
		.i_pat_en(ctrl_pat_en), .i_col(tim_col), .i_row(tim_row), .o_dot(dot)
	);

	clut_lookup u_lookup (
		.i_clk_6m(i_clk_6m), .i_rst_n(i_rst_n), .i_active(tim_active),
		.i_hsync_n(tim_hsync_n), .i_vsync_n(tim_vsync_n), .i_bank(frame_bank),
		.i_dot(dot), .o_pix_req(pix_req), .o_pix_addr(pix_addr), .i_pix_data(pix_data),
		.o_red(o_red), .o_green(o_green), .o_blue(o_blue),
		.o_active(o_active), .o_hsync_n(o_hsync_n), .o_vsync_n(o_vsync_n)
	);

	clut_ram_arb u_ram (
		.i_clk_6m(i_clk_6m), .i_rst_n(i_rst_n),
		.i_pix_req(pix_req), .i_pix_addr(pix_addr), .o_pix_data(pix_data),
		.i_host_req(host_req), .i_host_we(host_we), .i_host_addr(host_addr),
		.i_host_wdata(host_wdata), .o_host_ack(host_ack), .o_host_rdata(host_rdata)
	);

	apb_clut_port u_apb (
		.i_clk_6m(i_clk_6m), .i_rst_n(i_rst_n), .i_psel(i_psel), .i_penable(i_penable),
		.i_pwrite(i_pwrite), .i_paddr(i_paddr), .i_pwdata(i_pwdata),
		.o_prdata(o_prdata), .o_pready(o_pready),
		.o_host_req(host_req), .o_host_we(host_we), .o_host_addr(host_addr),
		.o_host_wdata(host_wdata), .i_host_ack(host_ack), .i_host_rdata(host_rdata),
		.o_ctrl_bank(ctrl_bank), .o_ctrl_pat_en(ctrl_pat_en)
	);

endmodule

`default_nettype wire

/* dv/videogen_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "videogen_cfg.svh"

module videogen_checker (
	input wire logic                  i_clk_6m,
	input wire logic                  i_rst_n,
	input wire logic                  i_pix_req,
	input wire logic                  i_host_req,
	input wire logic                  i_host_ack,
	input wire logic                  i_active,
	input wire logic [`VG_COMP_W-1:0] i_red,
	input wire logic [`VG_COMP_W-1:0] i_green,
	input wire logic [`VG_COMP_W-1:0] i_blue
);

	// Failure count, read by the testbench at the end of the run
	int n_fail = 0;

	////////////////////////////////////////////////////////////////////////////
	// Palette arbiter
	////////////////////////////////////////////////////////////////////////////

	// Pixel port owns the RAM in every cycle it asks
	a_ack_free: assert property (@(posedge i_clk_6m) disable iff (!i_rst_n)
		i_host_ack |-> !i_pix_req)
		else begin
			n_fail++;
			$error("host ack in a cycle with a pixel read");
		end

	// Host request stays up until its ack
	a_req_hold: assert property (@(posedge i_clk_6m) disable iff (!i_rst_n)
		(i_host_req && !i_host_ack) |=> i_host_req)
		else begin
			n_fail++;
			$error("host request dropped before ack");
		end

	////////////////////////////////////////////////////////////////////////////
	// Video output
	////////////////////////////////////////////////////////////////////////////

	// Black outside the visible window
	a_blank_black: assert property (@(posedge i_clk_6m) disable iff (!i_rst_n)
		!i_active |-> (i_red == '0 && i_green == '0 && i_blue == '0))
		else begin
			n_fail++;
			$error("RGB not zero while blanked");
		end

endmodule

// Arbiter ports and video outputs as seen from the top level
bind videogen_top videogen_checker u_checker (
	.i_clk_6m(i_clk_6m), .i_rst_n(i_rst_n), .i_pix_req(pix_req),
	.i_host_req(host_req), .i_host_ack(host_ack), .i_active(o_active),
	.i_red(o_red), .i_green(o_green), .i_blue(o_blue)
);

`default_nettype wire

/* dv/videogen_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "videogen_cfg.svh"

module videogen_tb;

	// Stimulus table operations
	localparam int OP_WR     = 0;
	localparam int OP_RD     = 1;
	// Read issued right after a visible line starts
	localparam int OP_RD_ACT = 2;
	localparam int OP_FRAMES = 3;
	localparam int OP_SCORE  = 4;
	// Wait for a given visible row
	localparam int OP_MID    = 5;

	localparam int CLK_NS     = 10;
	localparam int LINE_CLKS  = `VG_TOTAL_COLS;
	localparam int FRAME_CLKS = `VG_TOTAL_COLS * `VG_TOTAL_ROWS;
	localparam int ACT_PX     = `VG_ACTIVE_COLS * `VG_ACTIVE_ROWS;

	logic                    clk;
	logic                    rst_n;
	logic                    psel;
	logic                    penable;
	logic                    pwrite;
	logic [`VG_APB_AW-1:0]   paddr;
	logic [`VG_APB_DW-1:0]   pwdata;
	logic [`VG_APB_DW-1:0]   prdata;
	logic                    pready;
	logic                    o_hsync_n;
	logic                    o_vsync_n;
	logic                    o_active;
	logic [`VG_COMP_W-1:0]   o_red;
	logic [`VG_COMP_W-1:0]   o_green;
	logic [`VG_COMP_W-1:0]   o_blue;

	// One stimulus step per table index
	int                      tbl_op [$];
	logic [`VG_APB_AW-1:0]   tbl_addr [$];
	logic [`VG_APB_DW-1:0]   tbl_data [$];
	logic [`VG_APB_DW-1:0]   tbl_exp [$];
	logic                    tbl_built = 1'b0;

	// Reference model of palette and control register
	videogen_pkg::pal_word_t pal_model [`VG_PAL_DEPTH];
	logic                    ctrl_bank_m = 1'b0;
	logic                    ctrl_pat_m = 1'b0;
	logic                    wr_pend = 1'b0;
	videogen_pkg::pal_idx_t  wr_pend_addr;
	videogen_pkg::pal_word_t wr_pend_data;
	logic [4:0]              bank_hist = '0;
	logic [4:0]              pat_hist = '0;
	logic                    frame_bank_m = 1'b0;
	logic                    score_on = 1'b0;

	// Raster rebuilt from the video outputs
	int                      frames = 0;
	int                      act_row = 0;
	int                      act_col = 0;
	int                      frame_px = 0;
	int                      hs_len = 0;
	int                      vs_len = 0;
	logic                    prev_act = 1'b0;
	logic                    prev_hs = 1'b1;
	logic                    prev_vs = 1'b1;
	logic                    frame_open = 1'b0;
	logic [`VG_ACC_W-1:0]    col_acc_m = '0;
	logic [`VG_ACC_W-1:0]    row_acc_m = '0;

	videogen_top UUT (
		.i_clk_6m(clk), .i_rst_n(rst_n), .i_psel(psel), .i_penable(penable),
		.i_pwrite(pwrite), .i_paddr(paddr), .i_pwdata(pwdata),
		.o_prdata(prdata), .o_pready(pready),
		.o_hsync_n(o_hsync_n), .o_vsync_n(o_vsync_n), .o_active(o_active),
		.o_red(o_red), .o_green(o_green), .o_blue(o_blue)
	);

	initial begin : clock_gen
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	task automatic report_error(input string msg);
		$display("Error at %0t ns: %s", $time, msg);
		$display("TEST RESULT: FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic add_step(input int op, input logic [`VG_APB_AW-1:0] addr,
			input logic [`VG_APB_DW-1:0] data, input logic [`VG_APB_DW-1:0] exp);
		tbl_op.push_back(op);
		tbl_addr.push_back(addr);
		tbl_data.push_back(data);
		tbl_exp.push_back(exp);
	endtask

	// Setup and access phases with pready sampled mid-cycle
	task automatic apb_access(input logic wr, input logic [`VG_APB_AW-1:0] addr,
			input logic [`VG_APB_DW-1:0] wdata, output logic [`VG_APB_DW-1:0] rdata,
			output int waits);
		waits = 0;
		@(posedge clk);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= wr;
		paddr   <= addr;
		pwdata  <= wdata;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		while (!pready) begin
			waits++;
			@(negedge clk);
		end
		rdata = prdata;
		// Completion edge
		@(posedge clk);
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic build_table();
		videogen_pkg::pal_word_t gold [`VG_PAL_DEPTH];
		logic [`VG_APB_DW-1:0]   wd;
		videogen_pkg::pal_idx_t  idx;
		int                      k;
		// Control reads zero out of reset
		add_step(OP_RD, `VG_CTRL_ADDR, '0, '0);
		// Fill both banks since the RAM has no reset
		for (k = 0; k < `VG_PAL_DEPTH; k++) begin
			wd = $urandom;
			gold[k] = wd[`VG_PAL_W-1:0];
			add_step(OP_WR, k << 2, wd, '0);
		end
		add_step(OP_FRAMES, '0, 1, '0);
		add_step(OP_SCORE, '0, '0, '0);
		add_step(OP_WR, `VG_CTRL_ADDR, 32'h2, '0);
		add_step(OP_FRAMES, '0, 1, '0);
		// Random entries in alternating banks with noise in the upper write bits
		for (k = 0; k < 8; k++) begin
			wd = $urandom;
			idx = {k[0], 8'($urandom)};
			gold[idx] = wd[`VG_PAL_W-1:0];
			add_step(OP_WR, idx << 2, wd, '0);
			add_step((k < 4) ? OP_RD_ACT : OP_RD, idx << 2, '0, {20'h0, gold[idx]});
		end
		add_step(OP_RD, `VG_CTRL_ADDR, '0, 32'h2);
		// Bank switch in the middle of a frame
		add_step(OP_MID, '0, 100, '0);
		add_step(OP_WR, `VG_CTRL_ADDR, 32'h3, '0);
		add_step(OP_FRAMES, '0, 2, '0);
		add_step(OP_RD, `VG_CTRL_ADDR, '0, 32'h3);
		// Pattern off shows flat entry 0 of bank 1
		add_step(OP_WR, `VG_CTRL_ADDR, 32'h1, '0);
		add_step(OP_FRAMES, '0, 2, '0);
		add_step(OP_WR, `VG_CTRL_ADDR, 32'h0, '0);
		add_step(OP_RD, `VG_CTRL_ADDR, '0, '0);
		add_step(OP_FRAMES, '0, 1, '0);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Pixel scoreboard sampled on the falling edge
	////////////////////////////////////////////////////////////////////////////

	always @(negedge clk) begin : scoreboard
		videogen_pkg::dot_t     dot_m;
		videogen_pkg::pal_idx_t idx_m;
		if (rst_n) begin
			// Control history where bit k is k cycles back
			bank_hist = {bank_hist[3:0], ctrl_bank_m};
			pat_hist  = {pat_hist[3:0], ctrl_pat_m};
			// Bank for the new frame was sampled four cycles before vsync shows
			if (prev_vs && !o_vsync_n) begin
				if (frame_open) begin
					assert (frame_px == ACT_PX && act_row == `VG_ACTIVE_ROWS)
						else report_error($sformatf("frame had %0d pixels in %0d lines",
							frame_px, act_row));
				end
				frame_open   = 1'b1;
				frames++;
				frame_px     = 0;
				act_row      = 0;
				frame_bank_m = bank_hist[4];
			end
			// Sync pulse widths
			if (!o_hsync_n) begin
				hs_len++;
			end else if (!prev_hs) begin
				assert (hs_len == `VG_HSYNC_LEN)
					else report_error($sformatf("hsync low for %0d clocks", hs_len));
				hs_len = 0;
			end
			if (!o_vsync_n) begin
				vs_len++;
			end else if (!prev_vs) begin
				assert (vs_len == `VG_VSYNC_LEN * LINE_CLKS)
					else report_error($sformatf("vsync low for %0d clocks", vs_len));
				vs_len = 0;
			end
			if (o_active) begin
				act_col = prev_act ? act_col + 1 : 0;
				// Gradient rule stepped per visible pixel
				if (act_col == 0) begin
					col_acc_m = '0;
					if (act_row == 0 || act_row == `VG_SPLIT_ROW) begin
						row_acc_m = '0;
					end else begin
						row_acc_m = row_acc_m + `VG_ROW_STEP;
					end
				end else begin
					col_acc_m = col_acc_m + `VG_COL_STEP;
				end
				// Enable was seen three cycles before the RGB
				dot_m = pat_hist[3] ? {row_acc_m[15:13], col_acc_m[15:11]} : '0;
				idx_m = {frame_bank_m, dot_m};
				if (score_on) begin
					assert ({o_red, o_green, o_blue} === pal_model[idx_m])
						else report_error($sformatf("pixel %0d,%0d rgb %03h expected %03h",
							act_col, act_row, {o_red, o_green, o_blue}, pal_model[idx_m]));
				end
				frame_px++;
			end else begin
				assert ({o_red, o_green, o_blue} == '0)
					else report_error("RGB not black during blanking");
				if (prev_act) begin
					assert (act_col == `VG_ACTIVE_COLS - 1)
						else report_error($sformatf("line had %0d pixels", act_col + 1));
					act_row++;
				end
			end
			// A write that just completed is only visible to later reads
			if (wr_pend) begin
				pal_model[wr_pend_addr] = wr_pend_data;
				wr_pend = 1'b0;
			end
			prev_act = o_active;
			prev_hs  = o_hsync_n;
			prev_vs  = o_vsync_n;
		end
	end

	// One line per table step plus the frames waited and three spare
	initial begin : watchdog
		int run_frames;
		int j;
		run_frames = 0;
		wait (tbl_built);
		for (j = 0; j < tbl_op.size(); j++) begin
			if (tbl_op[j] == OP_FRAMES) begin
				run_frames += int'(tbl_data[j]);
			end else if (tbl_op[j] == OP_MID) begin
				// Reaching a given row takes up to one frame
				run_frames++;
			end
		end
		#((tbl_op.size() * LINE_CLKS + (run_frames + 3) * FRAME_CLKS) * CLK_NS);
		$display("Timeout: the run did not finish in time");
		$display("TEST RESULT: FAIL");
		$fatal(1, "watchdog expired");
	end

	initial begin : stimulus
		int                    seed_ret;
		int                    i;
		int                    waits;
		int                    target;
		logic [`VG_APB_DW-1:0] rdata;
		logic                  blank_seen;
		seed_ret = $urandom(89893);
		rst_n   <= 1'b0;
		psel    <= 1'b0;
		penable <= 1'b0;
		pwrite  <= 1'b0;
		paddr   <= '0;
		pwdata  <= '0;
		build_table();
		tbl_built = 1'b1;
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		for (i = 0; i < tbl_op.size(); i++) begin
			case (tbl_op[i])
				OP_WR: begin
					apb_access(1'b1, tbl_addr[i], tbl_data[i], rdata, waits);
					if (tbl_addr[i] == `VG_CTRL_ADDR) begin
						ctrl_bank_m = tbl_data[i][0];
						ctrl_pat_m  = tbl_data[i][1];
					end else begin
						wr_pend_addr = tbl_addr[i][`VG_IDX_W+1:2];
						wr_pend_data = tbl_data[i][`VG_PAL_W-1:0];
						wr_pend      = 1'b1;
					end
				end
				OP_RD, OP_RD_ACT: begin
					if (tbl_op[i] == OP_RD_ACT) begin
						while (!(prev_act && act_col < 16)) @(posedge clk);
					end
					apb_access(1'b0, tbl_addr[i], '0, rdata, waits);
					assert (rdata == tbl_exp[i])
						else report_error($sformatf("read %03h got %08h expected %08h",
							tbl_addr[i], rdata, tbl_exp[i]));
					if (tbl_op[i] == OP_RD_ACT) begin
						// Held off for the rest of the visible line
						assert (waits >= `VG_ACTIVE_COLS - 32)
							else report_error($sformatf(
								"read in the visible area waited only %0d cycles", waits));
						// Output blanking trails the pixel path by the pipeline depth
						blank_seen = 1'b0;
						repeat (3) begin
							@(negedge clk);
							if (!o_active) blank_seen = 1'b1;
						end
						assert (blank_seen)
							else report_error("read finished before the line ended");
					end
				end
				OP_FRAMES: begin
					target = frames + int'(tbl_data[i]);
					while (frames < target) @(posedge clk);
				end
				OP_MID: begin
					while (act_row != int'(tbl_data[i])) @(posedge clk);
				end
				OP_SCORE: score_on = 1'b1;
				default: report_error("unknown step in the stimulus table");
			endcase
		end
		if (UUT.u_checker.n_fail == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("Bound assertions failed %0d times", UUT.u_checker.n_fail);
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* flist.f */
+incdir+hw
hw/videogen_pkg.sv
hw/video_timing.sv
hw/dot_pattern.sv
hw/clut_ram_arb.sv
hw/clut_lookup.sv
hw/apb_clut_port.sv
hw/videogen_top.sv
dv/videogen_checker.sv
dv/videogen_tb.sv

/* Bender.yml */
package:
  name: videogen

sources:
  - include_dirs:
      - hw
    files:
      - hw/videogen_pkg.sv
      - hw/video_timing.sv
      - hw/dot_pattern.sv
      - hw/clut_ram_arb.sv
      - hw/clut_lookup.sv
      - hw/apb_clut_port.sv
      - hw/videogen_top.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - dv/videogen_checker.sv
      - dv/videogen_tb.sv
